// ==== alu.sv ====
module alu #(
  parameter int tag_w = 5
) (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     op_valid,
  input  logic [exu_pkg::op_w-1:0] op,
  input  logic [31:0]              src1,
  input  logic [31:0]              src2,
  input  logic [tag_w-1:0]         tag,
  input  logic                     gnt,
  output logic                     req,
  output logic [tag_w-1:0]         res_tag,
  output logic [31:0]              res_data
);

  logic                      accept;
  logic                      sub_mode;
  logic [exu_pkg::xlen-1:0]  adder_b;
  logic [exu_pkg::xlen-1:0]  adder_sum;
  logic                      adder_cout;
  logic [exu_pkg::xlen-1:0]  slt_res;
  logic [exu_pkg::xlen-1:0]  sltu_res;
  logic [exu_pkg::xlen-1:0]  sll_res;
  logic [2*exu_pkg::xlen-1:0] sr64_res;
  logic [exu_pkg::xlen-1:0]  result;

  assign accept = op_valid & |(op & exu_pkg::alu_ops);

  // one adder takes inverted b plus carry-in for subtract and compares
  assign sub_mode = op[exu_pkg::op_sub] | op[exu_pkg::op_slt] | op[exu_pkg::op_sltu];
  assign adder_b  = sub_mode ? ~src2 : src2;

  assign {adder_cout, adder_sum} = {1'b0, src1} + {1'b0, adder_b}
                                 + {{exu_pkg::xlen{1'b0}}, sub_mode};

  // signed less-than from operand signs and the difference sign
  assign slt_res[exu_pkg::xlen-1:1] = '0;
  assign slt_res[0] = (src1[31] & ~src2[31])
                    | (~(src1[31] ^ src2[31]) & adder_sum[31]);

  // borrow out means src1 < src2 unsigned
  assign sltu_res[exu_pkg::xlen-1:1] = '0;
  assign sltu_res[0] = ~adder_cout;

  assign sll_res  = src1 << src2[4:0];
  assign sr64_res = {{exu_pkg::xlen{op[exu_pkg::op_sra] & src1[31]}}, src1} >> src2[4:0];

  // AND-OR select over the one-hot op
  assign result =
      ({32{op[exu_pkg::op_add] | op[exu_pkg::op_sub]}} & adder_sum)
    | ({32{op[exu_pkg::op_slt]}}                       & slt_res)
    | ({32{op[exu_pkg::op_sltu]}}                      & sltu_res)
    | ({32{op[exu_pkg::op_and]}}                       & (src1 & src2))
    | ({32{op[exu_pkg::op_nor]}}                       & ~(src1 | src2))
    | ({32{op[exu_pkg::op_or]}}                        & (src1 | src2))
    | ({32{op[exu_pkg::op_xor]}}                       & (src1 ^ src2))
    | ({32{op[exu_pkg::op_sll]}}                       & sll_res)
    | ({32{op[exu_pkg::op_srl] | op[exu_pkg::op_sra]}} & sr64_res[31:0])
    | ({32{op[exu_pkg::op_lui]}}                       & src2);

  // pending flag where a new accept wins over the grant of the old one
  always_ff @(posedge clk) begin
    if (resetn) begin
      req <= 1'b0;
    end else if (accept) begin
      req <= 1'b1;
    end else if (gnt) begin
      req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res_data <= result;
      res_tag  <= tag;
    end
  end

  // the issuer drives exactly one operation bit
  op_onehot_a: assert property (
    @(posedge clk) disable iff (resetn)
    op_valid |-> $onehot(op)
  );

endmodule

// ==== div_unit.sv ====
module div_unit #(
  parameter int tag_w = 5
) (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     op_valid,
  input  logic [exu_pkg::op_w-1:0] op,
  input  logic [31:0]              src1,
  input  logic [31:0]              src2,
  input  logic [tag_w-1:0]         tag,
  input  logic                     gnt,
  output logic                     req,
  output logic [tag_w-1:0]         res_tag,
  output logic [31:0]              res_data,
  output logic                     busy
);

  logic                     accept;
  logic                     sgn;
  logic                     a_neg;
  logic                     b_neg;
  logic                     iter;      // shift-subtract running
  logic                     fix;       // sign-fix cycle
  logic [4:0]               cnt;
  logic [exu_pkg::xlen-1:0] quo;       // dividend shifts out as quotient shifts in
  logic [exu_pkg::xlen-1:0] dvs;
  logic [exu_pkg::xlen-1:0] rem;
  logic [exu_pkg::xlen-1:0] dvd_raw;
  logic                     q_neg;
  logic                     r_neg;
  logic                     want_rem;
  logic                     zero_div;
  logic [exu_pkg::xlen:0]   shifted;
  logic [exu_pkg::xlen:0]   diff;
  logic [exu_pkg::xlen-1:0] fixed;

  assign accept = op_valid & |(op & exu_pkg::div_ops);
  assign sgn    = op[exu_pkg::op_div] | op[exu_pkg::op_mod];
  assign a_neg  = sgn & src1[31];
  assign b_neg  = sgn & src2[31];

  // restoring step keeps the difference only when there is no borrow
  assign shifted = {rem, quo[31]};
  assign diff    = shifted - {1'b0, dvs};

  always_comb begin
    if (zero_div) begin
      fixed = want_rem ? dvd_raw : exu_pkg::div_zero_quot;
    end else if (want_rem) begin
      fixed = r_neg ? -rem : rem;   // remainder follows dividend
    end else begin
      fixed = q_neg ? -quo : quo;
    end
  end

  always_ff @(posedge clk) begin
    if (resetn) begin
      busy <= 1'b0;
      iter <= 1'b0;
      fix  <= 1'b0;
      req  <= 1'b0;
      cnt  <= '0;
    end else begin
      fix <= iter && cnt == 5'd31;
      if (accept) begin
        busy <= 1'b1;
        iter <= 1'b1;
        cnt  <= '0;
      end else if (iter) begin
        cnt <= cnt + 5'd1;
        if (cnt == 5'd31) begin
          iter <= 1'b0;
        end
      end
      if (fix) begin
        req <= 1'b1;
      end else if (gnt) begin
        req  <= 1'b0;
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      quo      <= a_neg ? -src1 : src1;   // magnitudes for signed ops
      dvs      <= b_neg ? -src2 : src2;
      rem      <= '0;
      dvd_raw  <= src1;
      q_neg    <= a_neg ^ b_neg;
      r_neg    <= a_neg;
      want_rem <= op[exu_pkg::op_mod] | op[exu_pkg::op_modu];
      zero_div <= src2 == '0;
      res_tag  <= tag;
    end else if (iter) begin
      rem <= diff[32] ? shifted[31:0] : diff[31:0];
      quo <= {quo[30:0], ~diff[32]};
    end
    if (fix) begin
      res_data <= fixed;
    end
  end

  // the arbiter stall must hold off issue for the whole division
  no_accept_busy_a: assert property (
    @(posedge clk) disable iff (resetn)
    accept |-> !busy
  );

endmodule

// ==== exu.f ====
exu_pkg.sv
alu.sv
mul.sv
div_unit.sv
wb_arbiter.sv
exu_top.sv
tb_exu.sv

// ==== exu_pkg.sv ====
package exu_pkg;

  // datapath width
  localparam int xlen = 32;

  // one-hot operation word with one bit per operation
  localparam int op_w = 19;

  localparam int op_add   = 0;
  localparam int op_sub   = 1;
  localparam int op_slt   = 2;
  localparam int op_sltu  = 3;
  localparam int op_and   = 4;
  localparam int op_nor   = 5;
  localparam int op_or    = 6;
  localparam int op_xor   = 7;
  localparam int op_sll   = 8;
  localparam int op_srl   = 9;
  localparam int op_sra   = 10;
  localparam int op_lui   = 11;
  localparam int op_mul   = 12;   // low half of product
  localparam int op_mulh  = 13;   // signed high half
  localparam int op_mulhu = 14;   // unsigned high half
  localparam int op_div   = 15;
  localparam int op_divu  = 16;
  localparam int op_mod   = 17;
  localparam int op_modu  = 18;

  // class masks for the execution units
  localparam logic [op_w-1:0] alu_ops = (op_w'(1) << op_add)
                                      | (op_w'(1) << op_sub)
                                      | (op_w'(1) << op_slt)
                                      | (op_w'(1) << op_sltu)
                                      | (op_w'(1) << op_and)
                                      | (op_w'(1) << op_nor)
                                      | (op_w'(1) << op_or)
                                      | (op_w'(1) << op_xor)
                                      | (op_w'(1) << op_sll)
                                      | (op_w'(1) << op_srl)
                                      | (op_w'(1) << op_sra)
                                      | (op_w'(1) << op_lui);

  localparam logic [op_w-1:0] mul_ops = (op_w'(1) << op_mul)
                                      | (op_w'(1) << op_mulh)
                                      | (op_w'(1) << op_mulhu);

  localparam logic [op_w-1:0] div_ops = (op_w'(1) << op_div)
                                      | (op_w'(1) << op_divu)
                                      | (op_w'(1) << op_mod)
                                      | (op_w'(1) << op_modu);

  // a zero divisor gives an all-ones quotient and the dividend as remainder
  // with no sign fix on either
  localparam logic [xlen-1:0] div_zero_quot = {xlen{1'b1}};

endpackage

// ==== exu_top.sv ====
module exu_top #(
  parameter int tag_w = 5
) (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     op_valid,
  input  logic [exu_pkg::op_w-1:0] op,
  input  logic [31:0]              src1,
  input  logic [31:0]              src2,
  input  logic [tag_w-1:0]         tag,
  output logic                     stall,
  output logic                     wb_valid,
  output logic [tag_w-1:0]         wb_tag,
  output logic [31:0]              wb_data
);

  logic             req_alu;
  logic             req_mul;
  logic             req_div;
  logic             gnt_alu;
  logic             gnt_mul;
  logic             gnt_div;
  logic [tag_w-1:0] tag_alu;
  logic [tag_w-1:0] tag_mul;
  logic [tag_w-1:0] tag_div;
  logic [31:0]      data_alu;
  logic [31:0]      data_mul;
  logic [31:0]      data_div;
  logic             div_busy;

  alu #(.tag_w(tag_w)) u_alu (
    .clk(clk), .resetn(resetn), .op_valid(op_valid), .op(op),
    .src1(src1), .src2(src2), .tag(tag), .gnt(gnt_alu),
    .req(req_alu), .res_tag(tag_alu), .res_data(data_alu)
  );

  mul #(.tag_w(tag_w)) u_mul (
    .clk(clk), .resetn(resetn), .op_valid(op_valid), .op(op),
    .src1(src1), .src2(src2), .tag(tag), .gnt(gnt_mul),
    .req(req_mul), .res_tag(tag_mul), .res_data(data_mul)
  );

  div_unit #(.tag_w(tag_w)) u_div (
    .clk(clk), .resetn(resetn), .op_valid(op_valid), .op(op),
    .src1(src1), .src2(src2), .tag(tag), .gnt(gnt_div),
    .req(req_div), .res_tag(tag_div), .res_data(data_div), .busy(div_busy)
  );

  wb_arbiter #(.tag_w(tag_w)) u_arb (
    .clk(clk), .resetn(resetn),
    .req_alu(req_alu), .req_mul(req_mul), .req_div(req_div),
    .tag_alu(tag_alu), .tag_mul(tag_mul), .tag_div(tag_div),
    .data_alu(data_alu), .data_mul(data_mul), .data_div(data_div),
    .div_busy(div_busy),
    .gnt_alu(gnt_alu), .gnt_mul(gnt_mul), .gnt_div(gnt_div),
    .stall(stall), .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_data(wb_data)
  );

endmodule

// ==== mul.sv ====
module mul #(
  parameter int tag_w = 5
) (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     op_valid,
  input  logic [exu_pkg::op_w-1:0] op,
  input  logic [31:0]              src1,
  input  logic [31:0]              src2,
  input  logic [tag_w-1:0]         tag,
  input  logic                     gnt,
  output logic                     req,
  output logic [tag_w-1:0]         res_tag,
  output logic [31:0]              res_data
);

  logic                              accept;
  logic                              advance;
  logic                              uns;
  logic                              s1_valid;
  logic [exu_pkg::xlen:0]            s1_a;
  logic [exu_pkg::xlen:0]            s1_b;
  logic                              s1_hi;
  logic [tag_w-1:0]                  s1_tag;
  logic signed [2*exu_pkg::xlen+1:0] product;

  assign accept  = op_valid & |(op & exu_pkg::mul_ops);
  assign advance = ~req | gnt;   // stage 2 empty or leaving
  assign uns     = op[exu_pkg::op_mulhu];

  // 33x33 signed covers both signed and unsigned forms
  assign product = $signed(s1_a) * $signed(s1_b);

  always_ff @(posedge clk) begin
    if (resetn) begin
      s1_valid <= 1'b0;
      req      <= 1'b0;
    end else begin
      if (accept) begin
        s1_valid <= 1'b1;
      end else if (advance) begin
        s1_valid <= 1'b0;
      end
      if (advance) begin
        req <= s1_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_a   <= {src1[31] & ~uns, src1};   // zero extend for mulhu
      s1_b   <= {src2[31] & ~uns, src2};
      s1_hi  <= op[exu_pkg::op_mulh] | op[exu_pkg::op_mulhu];
      s1_tag <= tag;
    end
    if (advance) begin
      res_data <= s1_hi ? product[63:32] : product[31:0];
      res_tag  <= s1_tag;
    end
  end

  // stall keeps the issuer off a held stage 1
  s1_hold_a: assert property (
    @(posedge clk) disable iff (resetn)
    (s1_valid && !advance) |-> !accept
  );

endmodule

// ==== tb_exu.sv ====
module tb_exu;

  localparam int tag_w  = 5;
  localparam int n_tags = 1 << tag_w;

  logic                     clk;
  logic                     resetn;
  logic                     op_valid;
  logic [exu_pkg::op_w-1:0] op;
  logic [31:0]              src1;
  logic [31:0]              src2;
  logic [tag_w-1:0]         tag;
  logic                     stall;
  logic                     wb_valid;
  logic [tag_w-1:0]         wb_tag;
  logic [31:0]              wb_data;

  // stimulus table filled once by load_table
  string       row_name [$];
  int          row_op [$];
  logic [31:0] row_a [$];
  logic [31:0] row_b [$];
  bit          row_rnd [$];
  int          n_rows = 0;

  // scoreboard indexed by tag
  logic        pending [n_tags];
  logic        used [n_tags];
  logic [31:0] exp_data [n_tags];
  string       exp_name [n_tags];
  int          outstanding = 0;

  logic [31:0] lfsr_state = 32'h3184;

  exu_top #(.tag_w(tag_w)) u_dut (
    .clk(clk), .resetn(resetn), .op_valid(op_valid), .op(op),
    .src1(src1), .src2(src2), .tag(tag),
    .stall(stall), .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_data(wb_data)
  );

  always #4 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED %s expected %08h actual %08h",
                          name, expected, actual));
    end
  endtask

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[30:0], lfsr_state[0]};   // one step per bit
    end
  endtask

  // expected result straight from the operation rules
  function automatic logic [31:0] ref_result(input int op_bit, input logic [31:0] a,
                                             input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] sp;
    logic [63:0]        up;
    logic signed [63:0] sq;
    logic [31:0]        r;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    sp = sa * sb;
    up = {32'b0, a} * {32'b0, b};
    sq = '0;
    case (op_bit)
      exu_pkg::op_add:   r = a + b;
      exu_pkg::op_sub:   r = a - b;
      exu_pkg::op_slt:   r = {31'b0, ($signed(a) < $signed(b))};
      exu_pkg::op_sltu:  r = {31'b0, (a < b)};
      exu_pkg::op_and:   r = a & b;
      exu_pkg::op_nor:   r = ~(a | b);
      exu_pkg::op_or:    r = a | b;
      exu_pkg::op_xor:   r = a ^ b;
      exu_pkg::op_sll:   r = a << b[4:0];
      exu_pkg::op_srl:   r = a >> b[4:0];
      exu_pkg::op_sra:   r = $signed(a) >>> b[4:0];
      exu_pkg::op_lui:   r = b;
      exu_pkg::op_mul:   r = sp[31:0];
      exu_pkg::op_mulh:  r = sp[63:32];
      exu_pkg::op_mulhu: r = up[63:32];
      exu_pkg::op_div: begin
        if (b == 0) begin
          r = 32'hffffffff;
        end else begin
          sq = sa / sb;   // truncates toward zero
          r  = sq[31:0];
        end
      end
      exu_pkg::op_divu:  r = (b == 0) ? 32'hffffffff : a / b;
      exu_pkg::op_mod: begin
        if (b == 0) begin
          r = a;
        end else begin
          sq = sa % sb;   // sign of the dividend
          r  = sq[31:0];
        end
      end
      exu_pkg::op_modu:  r = (b == 0) ? a : a % b;
      default:           r = 'x;
    endcase
    return r;
  endfunction

  task automatic add_row(input string name, input int op_bit, input logic [31:0] a,
                         input logic [31:0] b, input bit rnd);
    row_name.push_back(name);
    row_op.push_back(op_bit);
    row_a.push_back(a);
    row_b.push_back(b);
    row_rnd.push_back(rnd);
  endtask

  task automatic load_table();
    add_row("add_wrap",       exu_pkg::op_add,   32'hffffffff, 32'h00000001, 0);
    add_row("add_basic",      exu_pkg::op_add,   32'h12345678, 32'h11111111, 0);
    add_row("sub_wrap",       exu_pkg::op_sub,   32'h00000000, 32'h00000001, 0);
    add_row("sub_min",        exu_pkg::op_sub,   32'h80000000, 32'h00000001, 0);
    add_row("slt_neg_pos",    exu_pkg::op_slt,   32'h80000000, 32'h00000001, 0);
    add_row("slt_pos_neg",    exu_pkg::op_slt,   32'h00000001, 32'h80000000, 0);
    add_row("slt_equal",      exu_pkg::op_slt,   32'h00000005, 32'h00000005, 0);
    add_row("sltu_big_small", exu_pkg::op_sltu,  32'h80000000, 32'h00000001, 0);
    add_row("sltu_small_big", exu_pkg::op_sltu,  32'h00000001, 32'h80000000, 0);
    add_row("and_mix",        exu_pkg::op_and,   32'ha5a5f00f, 32'h0ff0ffff, 0);
    add_row("nor_mix",        exu_pkg::op_nor,   32'ha5a5f00f, 32'h0ff00000, 0);
    add_row("or_mix",         exu_pkg::op_or,    32'ha5a50000, 32'h0000f00f, 0);
    add_row("xor_mix",        exu_pkg::op_xor,   32'hffff0000, 32'h0ff00ff0, 0);
    add_row("sll_0",          exu_pkg::op_sll,   32'hdeadbeef, 32'h00000000, 0);
    add_row("sll_31",         exu_pkg::op_sll,   32'h00000003, 32'h0000001f, 0);
    add_row("sll_low5",       exu_pkg::op_sll,   32'h00000001, 32'h00000025, 0);
    add_row("srl_0",          exu_pkg::op_srl,   32'hdeadbeef, 32'h00000000, 0);
    add_row("srl_31",         exu_pkg::op_srl,   32'h80000000, 32'h0000001f, 0);
    add_row("sra_0",          exu_pkg::op_sra,   32'hdeadbeef, 32'h00000000, 0);
    add_row("sra_31",         exu_pkg::op_sra,   32'h80000000, 32'h0000001f, 0);
    add_row("sra_pos",        exu_pkg::op_sra,   32'h7ffffff0, 32'h00000004, 0);
    add_row("lui",            exu_pkg::op_lui,   32'h00000000, 32'habcde000, 0);
    add_row("mul_nn",         exu_pkg::op_mul,   32'hfffffffe, 32'hfffffffd, 0);
    add_row("mul_np",         exu_pkg::op_mul,   32'hfffffff9, 32'h00000007, 0);
    add_row("mul_ones",       exu_pkg::op_mul,   32'hffffffff, 32'hffffffff, 0);
    add_row("mulh_nn",        exu_pkg::op_mulh,  32'h80000000, 32'h80000000, 0);
    add_row("mulh_np",        exu_pkg::op_mulh,  32'hfffffffe, 32'h00000003, 0);
    add_row("mulh_ones",      exu_pkg::op_mulh,  32'hffffffff, 32'hffffffff, 0);
    add_row("mulhu_ones",     exu_pkg::op_mulhu, 32'hffffffff, 32'hffffffff, 0);
    add_row("mulhu_np",       exu_pkg::op_mulhu, 32'h80000000, 32'h00000002, 0);
    add_row("div_min_neg1",   exu_pkg::op_div,   32'h80000000, 32'hffffffff, 0);
    add_row("mod_min_neg1",   exu_pkg::op_mod,   32'h80000000, 32'hffffffff, 0);
    add_row("div_neg_pos",    exu_pkg::op_div,   32'hfffffff9, 32'h00000002, 0);
    add_row("mod_neg_pos",    exu_pkg::op_mod,   32'hfffffff9, 32'h00000002, 0);
    add_row("div_pos_neg",    exu_pkg::op_div,   32'h00000007, 32'hfffffffe, 0);
    add_row("mod_pos_neg",    exu_pkg::op_mod,   32'h00000007, 32'hfffffffe, 0);
    add_row("divu_big",       exu_pkg::op_divu,  32'hffffffff, 32'h00000002, 0);
    add_row("modu_big",       exu_pkg::op_modu,  32'hffffffff, 32'h00000010, 0);
    add_row("div_zero",       exu_pkg::op_div,   32'h92345678, 32'h00000000, 0);
    add_row("divu_zero",      exu_pkg::op_divu,  32'h87654321, 32'h00000000, 0);
    add_row("mod_zero",       exu_pkg::op_mod,   32'h87654321, 32'h00000000, 0);
    add_row("modu_zero",      exu_pkg::op_modu,  32'h12345678, 32'h00000000, 0);
    // back to back with classes mixed so results collide at the writeback port
    add_row("mix_mul",        exu_pkg::op_mul,   32'h00001234, 32'h00005678, 0);
    add_row("mix_divu",       exu_pkg::op_divu,  32'h00100000, 32'h00000007, 0);
    add_row("mix_mulh",       exu_pkg::op_mulh,  32'hc0000000, 32'h40000000, 0);
    add_row("mix_add",        exu_pkg::op_add,   32'h00000010, 32'h00000020, 0);
    add_row("mix_mulhu",      exu_pkg::op_mulhu, 32'hc0000000, 32'h40000000, 0);
    add_row("mix_xor",        exu_pkg::op_xor,   32'h0000ffff, 32'h00ff00ff, 0);
    add_row("mix_mul2",       exu_pkg::op_mul,   32'h7fffffff, 32'h00000003, 0);
    add_row("mix_sub",        exu_pkg::op_sub,   32'h00000003, 32'h00000005, 0);
    add_row("mix_mod",        exu_pkg::op_mod,   32'hffffff00, 32'h00000007, 0);
    add_row("mix_sll",        exu_pkg::op_sll,   32'h00000001, 32'h00000010, 0);
    // two random rows per operation
    for (int k = 0; k < 2 * exu_pkg::op_w; k++) begin
      add_row($sformatf("rand_%0d_op%0d", k, k % exu_pkg::op_w), k % exu_pkg::op_w,
              '0, '0, 1);
    end
    n_rows = row_name.size();
  endtask

  // sample the writeback port once per falling edge
  task automatic collect_writeback();
    if (wb_valid === 1'b1) begin
      if (used[wb_tag] !== 1'b1) begin
        abort_run($sformatf("result arrived with tag %0d that was never issued", wb_tag));
      end else if (pending[wb_tag] !== 1'b1) begin
        abort_run($sformatf("result for tag %0d arrived a second time", wb_tag));
      end else begin
        check_value(exp_name[wb_tag], exp_data[wb_tag], wb_data);
        pending[wb_tag] = 1'b0;
        outstanding--;
      end
    end
  endtask

  task automatic issue_row(input int r, input logic [tag_w-1:0] t);
    logic [31:0] a;
    logic [31:0] b;
    a = row_a[r];
    b = row_b[r];
    if (row_rnd[r]) begin
      draw_word(a);
      draw_word(b);
    end
    op_valid = 1'b1;
    op       = '0;
    op[row_op[r]] = 1'b1;
    src1     = a;
    src2     = b;
    tag      = t;
    exp_data[t] = ref_result(row_op[r], a, b);
    exp_name[t] = row_name[r];
    used[t]     = 1'b1;
    pending[t]  = 1'b1;
    outstanding++;
  endtask

  initial begin : watchdog
    wait (n_rows > 0);
    repeat (40 * n_rows + 100) @(posedge clk);
    abort_run("timeout, results did not drain within the allowed cycles");
  end

  initial begin : main
    int               row;
    logic [tag_w-1:0] next_tag;
    clk      = 1'b0;
    resetn   = 1'b1;
    op_valid = 1'b0;
    op       = '0;
    src1     = '0;
    src2     = '0;
    tag      = '0;
    row      = 0;
    next_tag = '0;
    for (int i = 0; i < n_tags; i++) begin
      pending[i] = 1'b0;
      used[i]    = 1'b0;
    end
    load_table();

    repeat (10) begin
      @(negedge clk);
      check_value("reset_stall", 32'h0, {31'b0, stall});
      check_value("reset_wb_valid", 32'h0, {31'b0, wb_valid});
    end
    resetn = 1'b0;
    @(negedge clk);
    check_value("post_reset_stall", 32'h0, {31'b0, stall});
    check_value("post_reset_wb_valid", 32'h0, {31'b0, wb_valid});

    while (row < n_rows || outstanding > 0) begin
      if (row > 0 || outstanding > 0) begin
        @(negedge clk);
        collect_writeback();
      end
      op_valid = 1'b0;
      op       = '0;
      // issue only into a free slot and while the DUT takes it
      if (row < n_rows && stall === 1'b0 && pending[next_tag] !== 1'b1) begin
        issue_row(row, next_tag);
        row++;
        next_tag++;
      end
    end

    // nothing more may come back in the quiet tail
    repeat (5) begin
      @(negedge clk);
      collect_writeback();
      check_value("idle_stall", 32'h0, {31'b0, stall});
    end

    if (outstanding == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run("some tags never returned a result");
    end
  end

endmodule

// ==== wb_arbiter.sv ====
module wb_arbiter #(
  parameter int tag_w = 5
) (
  input  logic             clk,
  input  logic             resetn,
  input  logic             req_alu,
  input  logic             req_mul,
  input  logic             req_div,
  input  logic [tag_w-1:0] tag_alu,
  input  logic [tag_w-1:0] tag_mul,
  input  logic [tag_w-1:0] tag_div,
  input  logic [31:0]      data_alu,
  input  logic [31:0]      data_mul,
  input  logic [31:0]      data_div,
  input  logic             div_busy,
  output logic             gnt_alu,
  output logic             gnt_mul,
  output logic             gnt_div,
  output logic             stall,
  output logic             wb_valid,
  output logic [tag_w-1:0] wb_tag,
  output logic [31:0]      wb_data
);

  // fixed priority with div first since it holds the longest
  assign gnt_div = req_div;
  assign gnt_mul = req_mul & ~req_div;
  assign gnt_alu = req_alu & ~req_mul & ~req_div;

  assign wb_valid = req_alu | req_mul | req_div;

  assign wb_tag  = ({tag_w{gnt_alu}} & tag_alu)
                 | ({tag_w{gnt_mul}} & tag_mul)
                 | ({tag_w{gnt_div}} & tag_div);

  assign wb_data = ({32{gnt_alu}} & data_alu)
                 | ({32{gnt_mul}} & data_mul)
                 | ({32{gnt_div}} & data_div);

  // any loser or a divide in flight blocks the next issue
  assign stall = (req_alu & ~gnt_alu)
               | (req_mul & ~gnt_mul)
               | div_busy;

  gnt_onehot_a: assert property (
    @(posedge clk) disable iff (resetn)
    $onehot0({gnt_alu, gnt_mul, gnt_div})
  );

  gnt_has_req_a: assert property (
    @(posedge clk) disable iff (resetn)
    (gnt_alu -> req_alu) && (gnt_mul -> req_mul) && (gnt_div -> req_div)
  );

endmodule
